/* rtl/cpu_isa_pkg.sv */
package cpu_isa_pkg;

        // --------------------
        // Basic widths
        // --------------------

        // Address or data word.
        typedef logic [31:0] word_t;

        // Condition field in bits 31:28 of every instruction.
        typedef logic [3:0]  cond_t;

        // Architectural register number.
        typedef logic [3:0]  reg_num_t;

        // Data-processing opcode in bits 24:21.
        typedef logic [3:0]  opcode_t;

        // --------------------
        // Encodings
        // --------------------

        localparam cond_t    COND_AL = 4'b1110;

        localparam reg_num_t REG_SP  = 4'd13;
        localparam reg_num_t REG_LR  = 4'd14;
        localparam reg_num_t REG_PC  = 4'd15;

        localparam opcode_t  OP_ADD  = 4'b0100;
        localparam opcode_t  OP_MOV  = 4'b1101;

        // BX Rm. Rm sits in bits 3:0.
        localparam word_t BX_INST      = 32'b????_0001_0010_1111_1111_1111_0001_????;

        // Single load/store with an immediate offset.
        localparam word_t LS_IMMEDIATE = 32'b????_010?_????_????_????_????_????_????;

        // Single load/store with a register offset shifted by an immediate.
        localparam word_t LS_REG_SHIFT = 32'b????_011?_????_????_????_????_???0_????;

        // Two-bit saturating branch predictor state.
        typedef enum logic [1:0]
        {
                SNT = 2'b00,
                WNT = 2'b01,
                WT  = 2'b10,
                ST  = 2'b11
        } branch_state_t;

endpackage

/* rtl/predecode_pkg.sv */
package predecode_pkg;

        import cpu_isa_pkg::*;

        // --------------------
        // Fetch side
        // --------------------

        // BTB lookup result. Target is meaningful only when valid is set.
        typedef struct packed
        {
                logic           valid;
                word_t          target;
        } btb_pred_t;

        // What fetch hands to this stage.
        typedef struct packed
        {
                word_t          instruction;
                logic           half_offset;
                logic           valid;
                word_t          pc;
                word_t          pc_plus_8;
                branch_state_t  taken;
                btb_pred_t      pred;
        } fetch_bundle_t;

        // --------------------
        // Decode side
        // --------------------

        // Registered output towards decode. ppc is the predicted next PC.
        typedef struct packed
        {
                word_t          instruction;
                logic           valid;
                word_t          pc;
                word_t          pc_plus_8;
                word_t          ppc;
                branch_state_t  taken;
        } decode_bundle_t;

        // Fetch redirect raised by this stage.
        typedef struct packed
        {
                logic           valid;
                word_t          target;
        } redirect_t;

        // Return-address stack request for the current instruction.
        typedef struct packed
        {
                logic           push;
                logic           pop;
                word_t          push_addr;
        } ras_op_t;

endpackage

/* rtl/predecode_branch_check.sv */
`timescale 1ns/1ps

module predecode_branch_check
        import cpu_isa_pkg::*;
        import predecode_pkg::*;
(
        input   fetch_bundle_t  i_fetch,
        input   logic           i_thumb,
        input   word_t          i_top,
        input   word_t          i_ppc_prev,

        output  decode_bundle_t o_next,
        output  redirect_t      o_redirect,
        output  logic           o_clear_btb,
        output  ras_op_t        o_ras_op
);

// True when the BTB did not predict the given target.
function automatic logic mispredict(input btb_pred_t pred, input word_t target);
begin
        mispredict = !pred.valid || (pred.target != target);
end
endfunction

word_t          instr;
cond_t          cond;
reg_num_t       rd;
reg_num_t       rn;
opcode_t        opcode;
word_t          step;
word_t          seq_pc;
word_t          offset;
word_t          br_target;
logic           pred_taken;
logic           is_branch;
logic           is_ret_bx;
logic           is_ret_mov;
logic           is_ret_ldm;
logic           is_ld_pc;
logic           is_dp_pc;
logic           is_return;
logic           is_jump_table;

// --------------------
// Field extraction
// --------------------

assign instr      = i_fetch.instruction;
assign cond       = instr[31:28];
assign rn         = instr[19:16];
assign rd         = instr[15:12];
assign opcode     = instr[24:21];

// Thumb instructions are half-words.
assign step       = i_thumb ? 32'd2 : 32'd4;
assign seq_pc     = i_fetch.pc + step;

// Sign-extended 24-bit branch offset.
assign offset     = {{8{instr[23]}}, instr[23:0]};
assign br_target  = i_fetch.pc_plus_8 +
                    (i_fetch.half_offset ? (offset << 1) : (offset << 2));

assign pred_taken = (i_fetch.taken == WT) || (i_fetch.taken == ST) || (cond == COND_AL);

// --------------------
// Classification
// --------------------

assign is_branch  = i_fetch.valid && (instr[27:25] == 3'b101);

assign is_ret_bx  = (instr ==? BX_INST) && (instr[3:0] == REG_LR);

assign is_ret_mov = instr ==? {4'b????, 2'b00, 1'b0, OP_MOV, 1'b0, 4'b0000,
                               REG_PC, 8'd0, REG_LR};

// LDM with PC in the register list.
assign is_ret_ldm = (instr[27:25] == 3'b100) && instr[20] && instr[15];

// Single load with PC as destination.
assign is_ld_pc   = ((instr ==? LS_IMMEDIATE) || (instr ==? LS_REG_SHIFT)) &&
                    (rd == REG_PC) && instr[20];

// ADD or MOV writing PC, excluding the multiply/extra load-store space.
assign is_dp_pc   = (instr[27:26] == 2'b00) && (rd == REG_PC) &&
                    (instr[25] || !instr[4] || !instr[7]) &&
                    ((opcode == OP_ADD) || (opcode == OP_MOV));

assign is_return  = i_fetch.valid &&
                    (is_ret_bx || is_ret_mov || is_ret_ldm ||
                     (is_ld_pc && (rn == REG_SP)));

assign is_jump_table = i_fetch.valid && (is_ld_pc || is_dp_pc);

// --------------------
// Prediction check
// --------------------

always_comb
begin
        o_next.instruction  = i_fetch.instruction;
        o_next.valid        = i_fetch.valid;
        o_next.pc           = i_fetch.pc;
        o_next.pc_plus_8    = i_fetch.pc_plus_8;
        o_next.ppc          = i_ppc_prev;
        o_next.taken        = i_fetch.taken;

        o_redirect.valid    = 1'b0;
        o_redirect.target   = '0;
        o_clear_btb         = 1'b0;

        o_ras_op.push       = 1'b0;
        o_ras_op.pop        = 1'b0;
        o_ras_op.push_addr  = seq_pc;

        if (is_branch)
        begin
                if (pred_taken)
                begin
                        o_next.ppc        = br_target;
                        o_redirect.target = br_target;
                        o_redirect.valid  = mispredict(i_fetch.pred, br_target);

                        if (cond == COND_AL)
                        begin
                                o_next.taken = ST;
                        end

                        // BL saves the return address.
                        o_ras_op.push = instr[24];
                end
                else
                begin
                        o_next.ppc = seq_pc;
                end
        end
        else if (is_return)
        begin
                if (pred_taken)
                begin
                        o_ras_op.pop      = 1'b1;
                        o_next.ppc        = i_top;
                        o_redirect.target = i_top;
                        o_redirect.valid  = mispredict(i_fetch.pred, i_top);

                        if (cond == COND_AL)
                        begin
                                o_next.taken = ST;
                        end
                end
                else
                begin
                        o_next.ppc = seq_pc;
                end
        end
        else if (is_jump_table)
        begin
                // Trust the BTB as is.
        end
        else if (i_fetch.valid)
        begin
                o_next.taken = SNT;

                // Not a branch, so a BTB hit here is stale.
                if (i_fetch.pred.valid)
                begin
                        o_redirect.valid  = 1'b1;
                        o_redirect.target = seq_pc;
                        o_next.ppc        = seq_pc;
                        o_clear_btb       = 1'b1;
                end
        end
        else
        begin
                o_next.taken = SNT;
        end
end

endmodule

/* rtl/return_stack.sv */
`timescale 1ns/1ps

module return_stack
        import cpu_isa_pkg::*;
        import predecode_pkg::*;
#(
        parameter int RAS_DEPTH = 8
)
(
        input   logic           i_clk,
        input   logic           i_reset,
        input   logic           i_advance,
        input   ras_op_t        i_op,
        output  word_t          o_top
);

localparam int                PTR_W   = $clog2(RAS_DEPTH);
localparam logic [PTR_W-1:0]  PTR_ONE = 1;

word_t                  ras_q [RAS_DEPTH];
logic [PTR_W-1:0]       ptr_q;
logic [PTR_W-1:0]       top_idx;

// Most recent entry sits just below the pointer.
assign top_idx = ptr_q - PTR_ONE;
assign o_top   = ras_q[top_idx];

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                ptr_q <= '0;

                for (int i = 0; i < RAS_DEPTH; i++)
                begin
                        ras_q[i] <= '0;
                end
        end
        else if (i_advance)
        begin
                // Pointer wraps, so an overflow overwrites the oldest entry.
                if (i_op.push)
                begin
                        ras_q[ptr_q] <= i_op.push_addr;
                        ptr_q        <= ptr_q + PTR_ONE;
                end
                else if (i_op.pop)
                begin
                        ptr_q <= top_idx;
                end
        end
end

endmodule

/* rtl/predecode_stage_reg.sv */
`timescale 1ns/1ps

module predecode_stage_reg
        import cpu_isa_pkg::*;
        import predecode_pkg::*;
(
        input   logic           i_clk,
        input   logic           i_reset,

        // From the branch check.
        input   decode_bundle_t i_next,
        input   redirect_t      i_redirect,
        input   logic           i_clear_btb,

        // Clears and stalls in priority order.
        input   logic           i_clear_from_writeback,
        input   logic           i_data_stall,
        input   logic           i_clear_from_alu,
        input   logic           i_stall_from_issue,

        output  decode_bundle_t o_decode,
        output  redirect_t      o_redirect,
        output  logic           o_clear_btb,
        output  logic           o_advance
);

// Stack moves only when this register takes new data.
assign o_advance = !i_clear_from_writeback &&
                   !i_data_stall           &&
                   !i_clear_from_alu       &&
                   !i_stall_from_issue     &&
                   !o_redirect.valid;

// --------------------
// Stage register
// --------------------

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                o_decode    <= '0;
                o_redirect  <= '0;
                o_clear_btb <= 1'b0;
        end
        else if (i_clear_from_writeback)
        begin
                o_decode.valid   <= 1'b0;
                o_decode.taken   <= SNT;
                o_redirect.valid <= 1'b0;
                o_clear_btb      <= 1'b0;
        end
        else if (i_data_stall)
        begin
                // Hold.
        end
        else if (i_clear_from_alu)
        begin
                o_decode.valid   <= 1'b0;
                o_decode.taken   <= SNT;
                o_redirect.valid <= 1'b0;
                o_clear_btb      <= 1'b0;
        end
        else if (i_stall_from_issue)
        begin
                // Hold.
        end
        else if (o_redirect.valid)
        begin
                // Bubble after our own redirect. Fetch restarts at the target.
                o_decode    <= '0;
                o_redirect  <= '0;
                o_clear_btb <= 1'b0;
        end
        else
        begin
                o_decode    <= i_next;
                o_redirect  <= i_redirect;
                o_clear_btb <= i_clear_btb;
        end
end

endmodule

/* rtl/predecode_top.sv */
`timescale 1ns/1ps

module predecode_top
        import cpu_isa_pkg::*;
        import predecode_pkg::*;
#(
        parameter int RAS_DEPTH = 8
)
(
        input   logic           i_clk,
        input   logic           i_reset,

        input   fetch_bundle_t  i_fetch,
        input   logic           i_thumb,

        input   logic           i_clear_from_writeback,
        input   logic           i_data_stall,
        input   logic           i_clear_from_alu,
        input   logic           i_stall_from_issue,

        output  decode_bundle_t o_decode,
        output  redirect_t      o_redirect,
        output  logic           o_clear_btb
);

decode_bundle_t next_bundle;
redirect_t      next_redirect;
logic           next_clear_btb;
ras_op_t        ras_op;
word_t          ras_top;
logic           advance;

// Combinational classify and check.
predecode_branch_check u_branch_check
(
        .i_fetch        (i_fetch),
        .i_thumb        (i_thumb),
        .i_top          (ras_top),
        .i_ppc_prev     (o_decode.ppc),
        .o_next         (next_bundle),
        .o_redirect     (next_redirect),
        .o_clear_btb    (next_clear_btb),
        .o_ras_op       (ras_op)
);

return_stack #(
        .RAS_DEPTH      (RAS_DEPTH)
) u_return_stack
(
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_advance      (advance),
        .i_op           (ras_op),
        .o_top          (ras_top)
);

predecode_stage_reg u_stage_reg
(
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_next                 (next_bundle),
        .i_redirect             (next_redirect),
        .i_clear_btb            (next_clear_btb),
        .i_clear_from_writeback (i_clear_from_writeback),
        .i_data_stall           (i_data_stall),
        .i_clear_from_alu       (i_clear_from_alu),
        .i_stall_from_issue     (i_stall_from_issue),
        .o_decode               (o_decode),
        .o_redirect             (o_redirect),
        .o_clear_btb            (o_clear_btb),
        .o_advance              (advance)
);

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen
#(
        parameter int CLK_PERIOD   = 40,
        parameter int RESET_CYCLES = 3
)
(
        output  logic   o_clk,
        output  logic   o_reset
);

initial
begin
        o_clk = 1'b0;
        forever #(CLK_PERIOD / 2) o_clk = ~o_clk;
end

// Synchronous reset released on a rising edge.
initial
begin
        o_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_reset <= 1'b0;
end

endmodule

/* verification/predecode_tb.sv */
`timescale 1ns/1ps

module predecode_tb
        import cpu_isa_pkg::*;
        import predecode_pkg::*;
();

localparam int CLK_PERIOD = 40;

logic           i_clk;
logic           i_reset;
fetch_bundle_t  i_fetch;
logic           i_thumb;
logic           i_clear_from_writeback;
logic           i_data_stall;
logic           i_clear_from_alu;
logic           i_stall_from_issue;
decode_bundle_t o_decode;
redirect_t      o_redirect;
logic           o_clear_btb;

// One vector storage entry per data line.
fetch_bundle_t  stim_fetch[$];
logic [3:0]     stim_ctl[$];
logic           stim_thumb[$];
decode_bundle_t exp_decode[$];
redirect_t      exp_redirect[$];
logic           exp_clear[$];

logic           vectors_loaded = 1'b0;

tb_clock_gen #(
        .CLK_PERIOD     (CLK_PERIOD),
        .RESET_CYCLES   (3)
) u_clock_gen
(
        .o_clk          (i_clk),
        .o_reset        (i_reset)
);

predecode_top dut0
(
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_fetch                (i_fetch),
        .i_thumb                (i_thumb),
        .i_clear_from_writeback (i_clear_from_writeback),
        .i_data_stall           (i_data_stall),
        .i_clear_from_alu       (i_clear_from_alu),
        .i_stall_from_issue     (i_stall_from_issue),
        .o_decode               (o_decode),
        .o_redirect             (o_redirect),
        .o_clear_btb            (o_clear_btb)
);

task automatic stop_run(input string msg);
begin
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped.");
end
endtask

// --------------------
// Compare tasks
// --------------------

task automatic check_decode(input decode_bundle_t got, input decode_bundle_t exp,
                            input string where);
begin
        if (got !== exp)
        begin
                stop_run($sformatf({"ERROR: t=%0t %s o_decode got instr=%h valid=%b pc=%h ",
                                    "pc8=%h ppc=%h taken=%0d, expected instr=%h valid=%b ",
                                    "pc=%h pc8=%h ppc=%h taken=%0d"},
                                   $time, where, got.instruction, got.valid, got.pc,
                                   got.pc_plus_8, got.ppc, got.taken, exp.instruction,
                                   exp.valid, exp.pc, exp.pc_plus_8, exp.ppc, exp.taken));
        end
end
endtask

// Target only matters when the redirect is valid.
task automatic check_redirect(input redirect_t got, input redirect_t exp, input string where);
begin
        if ((got.valid !== exp.valid) || (exp.valid && (got.target !== exp.target)))
        begin
                stop_run($sformatf("ERROR: t=%0t %s o_redirect got %b/%h, expected %b/%h",
                                   $time, where, got.valid, got.target,
                                   exp.valid, exp.target));
        end
end
endtask

task automatic check_flag(input logic got, input logic exp, input string where);
begin
        if (got !== exp)
        begin
                stop_run($sformatf("ERROR: t=%0t %s got %b, expected %b",
                                   $time, where, got, exp));
        end
end
endtask

// --------------------
// Vector handling
// --------------------

task automatic load_vectors();
        int             fd;
        int             n_fields;
        string          line;
        logic [31:0]    f [22];
        fetch_bundle_t  fb;
        decode_bundle_t db;
        redirect_t      rd;
begin
        fd = $fopen("verification/predecode_testdata.txt", "r");
        if (fd == 0)
        begin
                stop_run("Could not open verification/predecode_testdata.txt.");
        end
        while (!$feof(fd))
        begin
                line = "";
                if ($fgets(line, fd) == 0)
                begin
                        break;
                end
                if ((line.len() == 0) || (line[0] == "#"))
                begin
                        continue;
                end
                n_fields = $sscanf(line,
                        "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                        f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19],
                        f[20], f[21]);
                if (n_fields <= 0)
                begin
                        continue;
                end
                if (n_fields != 22)
                begin
                        stop_run($sformatf("A test data line has %0d fields instead of 22.",
                                           n_fields));
                end
                fb.instruction  = f[4];
                fb.half_offset  = f[5][0];
                fb.valid        = f[6][0];
                fb.pc           = f[7];
                fb.pc_plus_8    = f[8];
                fb.taken        = branch_state_t'(f[9][1:0]);
                fb.pred.valid   = f[10][0];
                fb.pred.target  = f[11];
                db.instruction  = f[13];
                db.valid        = f[14][0];
                db.pc           = f[15];
                db.pc_plus_8    = f[16];
                db.ppc          = f[17];
                db.taken        = branch_state_t'(f[18][1:0]);
                rd.valid        = f[19][0];
                rd.target       = f[20];
                stim_fetch.push_back(fb);
                stim_ctl.push_back({f[0][0], f[1][0], f[2][0], f[3][0]});
                stim_thumb.push_back(f[12][0]);
                exp_decode.push_back(db);
                exp_redirect.push_back(rd);
                exp_clear.push_back(f[21][0]);
        end
        $fclose(fd);
        if (stim_fetch.size() == 0)
        begin
                stop_run("The test data file holds no vectors.");
        end
end
endtask

// Control bits are {writeback clear, data stall, ALU clear, issue stall}.
task automatic apply_vector(input int k);
begin
        i_fetch                <= stim_fetch[k];
        i_thumb                <= stim_thumb[k];
        i_clear_from_writeback <= stim_ctl[k][3];
        i_data_stall           <= stim_ctl[k][2];
        i_clear_from_alu       <= stim_ctl[k][1];
        i_stall_from_issue     <= stim_ctl[k][0];
end
endtask

task automatic drive_idle();
begin
        i_fetch                <= '0;
        i_thumb                <= 1'b0;
        i_clear_from_writeback <= 1'b0;
        i_data_stall           <= 1'b0;
        i_clear_from_alu       <= 1'b0;
        i_stall_from_issue     <= 1'b0;
end
endtask

task automatic check_vector(input int k);
        string where;
begin
        where = $sformatf("vector %0d", k);
        check_decode(o_decode, exp_decode[k], where);
        check_redirect(o_redirect, exp_redirect[k], where);
        check_flag(o_clear_btb, exp_clear[k], {where, " o_clear_btb"});
end
endtask

// --------------------
// Main sequence
// --------------------

initial
begin
        int n;

        i_fetch                = '0;
        i_thumb                = 1'b0;
        i_clear_from_writeback = 1'b0;
        i_data_stall           = 1'b0;
        i_clear_from_alu       = 1'b0;
        i_stall_from_issue     = 1'b0;

        load_vectors();
        n = stim_fetch.size();
        vectors_loaded = 1'b1;

        @(negedge i_reset);
        @(negedge i_clk);
        check_flag(o_decode.valid, 1'b0, "o_decode.valid after reset");
        check_flag(o_redirect.valid, 1'b0, "o_redirect.valid after reset");
        check_flag(o_clear_btb, 1'b0, "o_clear_btb after reset");

        @(posedge i_clk);
        apply_vector(0);

        // Each edge registers one vector while the next one is driven.
        for (int k = 0; k < n; k++)
        begin
                @(posedge i_clk);
                if (k + 1 < n)
                begin
                        apply_vector(k + 1);
                end
                else
                begin
                        drive_idle();
                end
                @(negedge i_clk);
                check_vector(k);
        end

        $display("RESULT: PASS");
        $finish;
end

// Watchdog sized from the vector count plus reset and margin.
initial
begin
        wait (vectors_loaded);
        #((stim_fetch.size() + 10) * CLK_PERIOD);
        stop_run("Timeout: the test did not finish in the expected time.");
end

endmodule

/* verification/predecode_testdata.txt */
# wb ds alu is | instr half valid pc pc8 taken pvalid ptarget thumb |
# expected: instr valid pc pc8 ppc taken | redirect valid target | clear_btb
0 0 0 0  EB000010 0 1 100 108 0 0 0 0    EB000010 1 100 108 148 3  1 148  0
0 0 0 0  E1A00000 0 1 148 150 0 0 0 0    00000000 0 0 0 0 0  0 0  0
0 0 0 0  E12FFF1E 0 1 200 208 3 1 104 0  E12FFF1E 1 200 208 104 3  0 0  0
# Thumb BL with half-word offset, then MOV PC,LR back
0 0 0 0  EB000008 1 1 300 308 2 0 0 1    EB000008 1 300 308 318 3  1 318  0
0 0 0 0  EB000004 1 1 318 320 0 0 0 1    00000000 0 0 0 0 0  0 0  0
0 0 0 0  E1A0F00E 0 1 400 408 3 1 302 1  E1A0F00E 1 400 408 302 3  0 0  0
# Non-branch with a stale BTB hit
0 0 0 0  E0821003 0 1 500 508 2 1 600 0  E0821003 1 500 508 504 0  1 504  1
0 0 0 0  E1A00000 0 1 504 50C 0 0 0 0    00000000 0 0 0 0 0  0 0  0
0 0 0 0  1A000020 0 1 600 608 1 0 0 0    1A000020 1 600 608 604 1  0 0  0
0 0 0 0  E590F004 0 1 700 708 2 1 800 0  E590F004 1 700 708 604 2  0 0  0
# BL pushes 804, stalled and cleared BLs must not push
0 0 0 0  EB000010 0 1 800 808 3 1 848 0  EB000010 1 800 808 848 3  0 0  0
0 1 0 0  EB000020 0 1 900 908 0 0 0 0    EB000010 1 800 808 848 3  0 0  0
0 0 0 1  EB000020 0 1 900 908 0 0 0 0    EB000010 1 800 808 848 3  0 0  0
1 0 0 0  EB000020 0 1 900 908 0 0 0 0    EB000010 0 800 808 848 0  0 0  0
0 0 0 0  E1A00000 0 1 900 908 0 0 0 0    E1A00000 1 900 908 848 0  0 0  0
0 0 1 0  EB000020 0 1 A00 A08 0 0 0 0    E1A00000 0 900 908 848 0  0 0  0
0 0 0 0  E12FFF1E 0 1 A00 A08 3 1 999 0  E12FFF1E 1 A00 A08 804 3  1 804  0
0 0 0 0  E1A00000 0 1 804 80C 0 0 0 0    00000000 0 0 0 0 0  0 0  0
# Backward B, invalid slot, conditional BL, clear over the bubble
0 0 0 0  EAFFFFFE 0 1 B00 B08 1 1 B00 0  EAFFFFFE 1 B00 B08 B00 3  0 0  0
0 0 0 0  EB000010 0 0 C00 C08 3 1 C48 0  EB000010 0 C00 C08 B00 0  0 0  0
0 0 0 0  0B000001 0 1 D00 D08 2 0 0 0    0B000001 1 D00 D08 D0C 2  1 D0C  0
1 0 0 0  E1A00000 0 1 D0C D14 0 0 0 0    0B000001 0 D00 D08 D0C 0  0 0  0
0 0 0 0  E8BD8000 0 1 E00 E08 3 1 D04 0  E8BD8000 1 E00 E08 D04 3  0 0  0
0 0 0 0  E1A0F002 0 1 F00 F08 1 1 F40 0  E1A0F002 1 F00 F08 D04 1  0 0  0

/* all.f */
rtl/cpu_isa_pkg.sv
rtl/predecode_pkg.sv
rtl/predecode_branch_check.sv
rtl/return_stack.sv
rtl/predecode_stage_reg.sv
rtl/predecode_top.sv
verification/tb_clock_gen.sv
verification/predecode_tb.sv
